// ==== logic/ooo_pkg.sv ====
package ooo_pkg;

    localparam int NUM_PREGS      = 32;
    localparam int NUM_INIT_READY = 8;
    localparam int NUM_RD_PORTS   = 3;

    typedef logic [4:0]  preg_idx_t;
    typedef logic [31:0] data_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_t;

    // register format, fmt = 0
    typedef struct packed {
        logic        fmt;
        alu_op_t     op;
        preg_idx_t   rd;
        preg_idx_t   rs1;
        preg_idx_t   rs2;
        logic [12:0] unused;
    } instr_r_t;

    // immediate format, fmt = 1
    typedef struct packed {
        logic        fmt;
        alu_op_t     op;
        preg_idx_t   rd;
        preg_idx_t   rs1;
        logic [17:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        alu_op_t   op;
        logic      is_imm;
        preg_idx_t rd;
        preg_idx_t src1;
        preg_idx_t src2;
        data_t     imm;
        logic [1:0] src_rdy;
    } rs_entry_t;

    // value a register holds right after reset
    function automatic data_t init_value(int unsigned idx);
        return (idx < NUM_INIT_READY) ? data_t'(idx * 16 + 1) : '0;
    endfunction

endpackage

`timescale 1ns/1ps

interface wb_if #(
    parameter int LANES = 2
);
    import ooo_pkg::*;

    logic [LANES-1:0] vld;
    preg_idx_t        rd   [LANES];
    data_t            data [LANES];

    modport src (output vld, rd, data);
    modport snk (input vld, rd, data);
endinterface

interface issue_if #(
    parameter int DEPTH       = 8,
    parameter int ISSUE_WIDTH = 2
);
    import ooo_pkg::*;

    logic [ISSUE_WIDTH-1:0]   can_issue;
    logic [$clog2(DEPTH)-1:0] idx   [ISSUE_WIDTH];
    rs_entry_t                entry [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0]   deq;
    logic [ISSUE_WIDTH-1:0]   replay;

    modport queue (output can_issue, idx, entry, input deq, replay);
    modport read (input can_issue, idx, entry, output deq, replay);
endinterface

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_instr_vld,
    input  ooo_pkg::instr_u    i_instr,
    output logic               o_instr_rdy,
    input  logic               i_can_enq,
    output logic               o_enq_req,
    output ooo_pkg::rs_entry_t o_enq_entry,
    wb_if.snk                  wb
);
    import ooo_pkg::*;

    // set once a register holds its final value
    logic [NUM_PREGS-1:0] scoreboard;
    logic                 is_imm;
    preg_idx_t            rs1;
    preg_idx_t            rs2;
    logic                 rs1_rdy;
    logic                 rs2_rdy;

    assign is_imm = i_instr.i.fmt;
    // op, rd and rs1 sit at the same bits in both formats
    assign rs1    = i_instr.r.rs1;
    assign rs2    = is_imm ? '0 : i_instr.r.rs2;

    // a writeback in flight this cycle also counts as ready
    always_comb begin
        rs1_rdy = scoreboard[rs1];
        rs2_rdy = is_imm || scoreboard[rs2];
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (wb.vld[l] && wb.rd[l] == rs1) begin
                rs1_rdy = 1'b1;
            end
            if (wb.vld[l] && wb.rd[l] == rs2) begin
                rs2_rdy = 1'b1;
            end
        end
    end

    always_comb begin
        o_enq_entry.op      = i_instr.r.op;
        o_enq_entry.is_imm  = is_imm;
        o_enq_entry.rd      = i_instr.r.rd;
        o_enq_entry.src1    = rs1;
        o_enq_entry.src2    = rs2;
        // sign-extend the 18-bit immediate
        o_enq_entry.imm     = is_imm ? {{14{i_instr.i.imm[17]}}, i_instr.i.imm} : '0;
        o_enq_entry.src_rdy = {rs2_rdy, rs1_rdy};
    end

    assign o_instr_rdy = i_can_enq;
    assign o_enq_req   = i_instr_vld && i_can_enq;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            scoreboard <= {{(NUM_PREGS - NUM_INIT_READY){1'b0}}, {NUM_INIT_READY{1'b1}}};
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (wb.vld[l]) begin
                    scoreboard[wb.rd[l]] <= 1'b1;
                end
            end
            // destination becomes pending once accepted
            if (o_enq_req) begin
                scoreboard[o_enq_entry.rd] <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue #(
    parameter int DEPTH       = 8,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_enq_req,
    input  ooo_pkg::rs_entry_t i_enq_entry,
    output logic               o_can_enq,
    issue_if.queue             iq,
    wb_if.snk                  wb
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    rs_entry_t              ent [DEPTH];
    logic [DEPTH-1:0]       ent_vld;
    logic [DEPTH-1:0]       ent_issued;
    logic [DEPTH-1:0]       ent_rdy;
    logic                   free_vld;
    logic [IDX_W-1:0]       free_idx;
    logic                   enq_fire;
    logic [ISSUE_WIDTH-1:0] pick_vld;
    logic [IDX_W-1:0]       pick_idx [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] pick_q;
    logic [IDX_W-1:0]       idx_q [ISSUE_WIDTH];

    for (genvar k = 0; k < DEPTH; k++) begin : g_rdy
        assign ent_rdy[k] = ent_vld[k] && (&ent[k].src_rdy) && !ent_issued[k];
    end

    // lowest free slot
    always_comb begin
        free_vld = 1'b0;
        free_idx = '0;
        for (int k = DEPTH - 1; k >= 0; k--) begin
            if (!ent_vld[k]) begin
                free_vld = 1'b1;
                free_idx = IDX_W'(k);
            end
        end
    end

    assign o_can_enq = free_vld;
    assign enq_fire  = i_enq_req && free_vld;

    // each lane takes the lowest ready entry left by the lanes before it
    always_comb begin
        logic [DEPTH-1:0] taken;
        taken = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            pick_vld[l] = 1'b0;
            pick_idx[l] = '0;
            for (int k = DEPTH - 1; k >= 0; k--) begin
                if (ent_rdy[k] && !taken[k]) begin
                    pick_vld[l] = 1'b1;
                    pick_idx[l] = IDX_W'(k);
                end
            end
            if (pick_vld[l]) begin
                taken[pick_idx[l]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ent_vld    <= '0;
            ent_issued <= '0;
            pick_q     <= '0;
        end else begin
            pick_q <= pick_vld;
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (pick_vld[l]) begin
                    ent_issued[pick_idx[l]] <= 1'b1;
                end
                // operand read feedback on last cycle's picks
                if (pick_q[l] && iq.deq[l]) begin
                    ent_vld[idx_q[l]] <= 1'b0;
                end
                if (pick_q[l] && iq.replay[l]) begin
                    ent_issued[idx_q[l]] <= 1'b0;
                end
            end
            if (enq_fire) begin
                ent_vld[free_idx]    <= 1'b1;
                ent_issued[free_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= pick_idx;
        // wakeup from the writeback bus
        for (int k = 0; k < DEPTH; k++) begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (ent_vld[k] && wb.vld[l] && wb.rd[l] == ent[k].src1) begin
                    ent[k].src_rdy[0] <= 1'b1;
                end
                if (ent_vld[k] && wb.vld[l] && wb.rd[l] == ent[k].src2) begin
                    ent[k].src_rdy[1] <= 1'b1;
                end
            end
        end
        if (enq_fire) begin
            ent[free_idx] <= i_enq_entry;
        end
    end

    assign iq.can_issue = pick_q;
    assign iq.idx       = idx_q;

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_out
        assign iq.entry[l] = ent[idx_q[l]];
    end

endmodule

// ==== logic/operand_read.sv ====
`timescale 1ns/1ps

module operand_read #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                clk,
    input  logic                i_rst_n,
    issue_if.read               iq,
    output ooo_pkg::preg_idx_t  o_rd_addr [ooo_pkg::NUM_RD_PORTS],
    input  ooo_pkg::data_t      i_rd_data [ooo_pkg::NUM_RD_PORTS],
    output logic [ISSUE_WIDTH-1:0] o_ex_vld,
    output ooo_pkg::alu_op_t    o_ex_op [ISSUE_WIDTH],
    output ooo_pkg::data_t      o_ex_a  [ISSUE_WIDTH],
    output ooo_pkg::data_t      o_ex_b  [ISSUE_WIDTH],
    output ooo_pkg::preg_idx_t  o_ex_rd [ISSUE_WIDTH]
);
    import ooo_pkg::*;

    localparam int PORT_W = $clog2(NUM_RD_PORTS);

    // which read port feeds each operand
    logic [PORT_W-1:0] port_a [ISSUE_WIDTH];
    logic [PORT_W-1:0] port_b [ISSUE_WIDTH];

    // lanes claim ports in order, a lane that does not fit is replayed
    always_comb begin
        int used;
        int need;
        used      = 0;
        need      = 0;
        iq.deq    = '0;
        iq.replay = '0;
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            o_rd_addr[p] = '0;
        end
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            port_a[l] = '0;
            port_b[l] = '0;
            need      = iq.entry[l].is_imm ? 1 : 2;
            if (iq.can_issue[l]) begin
                if (used + need <= NUM_RD_PORTS) begin
                    iq.deq[l]       = 1'b1;
                    port_a[l]       = PORT_W'(used);
                    o_rd_addr[used] = iq.entry[l].src1;
                    if (!iq.entry[l].is_imm) begin
                        port_b[l]           = PORT_W'(used + 1);
                        o_rd_addr[used + 1] = iq.entry[l].src2;
                    end
                    used = used + need;
                end else begin
                    iq.replay[l] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_ex_vld <= '0;
        end else begin
            o_ex_vld <= iq.deq;
        end
    end

    // execute operands, immediate replaces B
    always_ff @(posedge clk) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            o_ex_op[l] <= iq.entry[l].op;
            o_ex_a[l]  <= i_rd_data[port_a[l]];
            o_ex_b[l]  <= iq.entry[l].is_imm ? iq.entry[l].imm : i_rd_data[port_b[l]];
            o_ex_rd[l] <= iq.entry[l].rd;
        end
    end

endmodule

// ==== logic/phys_regfile.sv ====
`timescale 1ns/1ps

module phys_regfile #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  ooo_pkg::preg_idx_t i_rd_addr [ooo_pkg::NUM_RD_PORTS],
    output ooo_pkg::data_t     o_rd_data [ooo_pkg::NUM_RD_PORTS],
    wb_if.snk                  wb
);
    import ooo_pkg::*;

    data_t regs [NUM_PREGS];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < NUM_PREGS; r++) begin
                regs[r] <= init_value(r);
            end
        end else begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (wb.vld[l]) begin
                    regs[wb.rd[l]] <= wb.data[l];
                end
            end
        end
    end

    // bypass the value being written this cycle
    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            o_rd_data[p] = regs[i_rd_addr[p]];
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (wb.vld[l] && wb.rd[l] == i_rd_addr[p]) begin
                    o_rd_data[p] = wb.data[l];
                end
            end
        end
    end

endmodule

// ==== logic/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [ISSUE_WIDTH-1:0] i_ex_vld,
    input  ooo_pkg::alu_op_t       i_ex_op [ISSUE_WIDTH],
    input  ooo_pkg::data_t         i_ex_a  [ISSUE_WIDTH],
    input  ooo_pkg::data_t         i_ex_b  [ISSUE_WIDTH],
    input  ooo_pkg::preg_idx_t     i_ex_rd [ISSUE_WIDTH],
    output logic [ISSUE_WIDTH-1:0] o_res_vld,
    output ooo_pkg::preg_idx_t     o_res_rd   [ISSUE_WIDTH],
    output ooo_pkg::data_t         o_res_data [ISSUE_WIDTH]
);
    import ooo_pkg::*;

    function automatic data_t alu_calc(alu_op_t op, data_t a, data_t b);
        data_t res;
        case (op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            // shift amount from the low five bits
            SLL:     res = a << b[4:0];
            SRL:     res = a >> b[4:0];
            SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: res = '0;
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_res_vld <= '0;
        end else begin
            o_res_vld <= i_ex_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            o_res_rd[l]   <= i_ex_rd[l];
            o_res_data[l] <= alu_calc(i_ex_op[l], i_ex_a[l], i_ex_b[l]);
        end
    end

endmodule

// ==== logic/writeback_result.sv ====
`timescale 1ns/1ps

module writeback_result #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic [ISSUE_WIDTH-1:0] i_res_vld,
    input  ooo_pkg::preg_idx_t     i_res_rd   [ISSUE_WIDTH],
    input  ooo_pkg::data_t         i_res_data [ISSUE_WIDTH],
    wb_if.src                      wb
);
    import ooo_pkg::*;

    // broadcast valid for one cycle per result
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wb.vld <= '0;
        end else begin
            wb.vld <= i_res_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            wb.rd[l]   <= i_res_rd[l];
            wb.data[l] <= i_res_data[l];
        end
    end

endmodule

// ==== logic/ooo_backend_top.sv ====
`timescale 1ns/1ps

module ooo_backend_top #(
    parameter int DEPTH       = 8,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_vld,
    input  logic [31:0]            i_instr,
    output logic                   o_instr_rdy,
    output logic [ISSUE_WIDTH-1:0] o_wb_vld,
    output ooo_pkg::preg_idx_t     o_wb_rd   [ISSUE_WIDTH],
    output ooo_pkg::data_t         o_wb_data [ISSUE_WIDTH]
);
    import ooo_pkg::*;

    instr_u                 instr_word;
    logic                   enq_req;
    rs_entry_t              enq_entry;
    logic                   can_enq;
    preg_idx_t              rd_addr [NUM_RD_PORTS];
    data_t                  rd_data [NUM_RD_PORTS];
    logic [ISSUE_WIDTH-1:0] ex_vld;
    alu_op_t                ex_op [ISSUE_WIDTH];
    data_t                  ex_a  [ISSUE_WIDTH];
    data_t                  ex_b  [ISSUE_WIDTH];
    preg_idx_t              ex_rd [ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] res_vld;
    preg_idx_t              res_rd   [ISSUE_WIDTH];
    data_t                  res_data [ISSUE_WIDTH];

    wb_if #(.LANES(ISSUE_WIDTH)) wb_bus ();
    issue_if #(.DEPTH(DEPTH), .ISSUE_WIDTH(ISSUE_WIDTH)) iq_bus ();

    assign instr_word = i_instr;

    instr_decode #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_decode (
        .clk(clk), .i_rst_n(i_rst_n), .i_instr_vld(i_instr_vld), .i_instr(instr_word),
        .o_instr_rdy(o_instr_rdy), .i_can_enq(can_enq), .o_enq_req(enq_req),
        .o_enq_entry(enq_entry), .wb(wb_bus)
    );

    issue_queue #(.DEPTH(DEPTH), .ISSUE_WIDTH(ISSUE_WIDTH)) u_queue (
        .clk(clk), .i_rst_n(i_rst_n), .i_enq_req(enq_req), .i_enq_entry(enq_entry),
        .o_can_enq(can_enq), .iq(iq_bus), .wb(wb_bus)
    );

    operand_read #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_read (
        .clk(clk), .i_rst_n(i_rst_n), .iq(iq_bus), .o_rd_addr(rd_addr), .i_rd_data(rd_data),
        .o_ex_vld(ex_vld), .o_ex_op(ex_op), .o_ex_a(ex_a), .o_ex_b(ex_b), .o_ex_rd(ex_rd)
    );

    phys_regfile #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_regfile (
        .clk(clk), .i_rst_n(i_rst_n), .i_rd_addr(rd_addr), .o_rd_data(rd_data), .wb(wb_bus)
    );

    alu_execute #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_alu (
        .clk(clk), .i_rst_n(i_rst_n), .i_ex_vld(ex_vld), .i_ex_op(ex_op), .i_ex_a(ex_a),
        .i_ex_b(ex_b), .i_ex_rd(ex_rd), .o_res_vld(res_vld), .o_res_rd(res_rd),
        .o_res_data(res_data)
    );

    writeback_result #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_wb (
        .clk(clk), .i_rst_n(i_rst_n), .i_res_vld(res_vld), .i_res_rd(res_rd),
        .i_res_data(res_data), .wb(wb_bus)
    );

    // writeback bus is also the result port
    assign o_wb_vld  = wb_bus.vld;
    assign o_wb_rd   = wb_bus.rd;
    assign o_wb_data = wb_bus.data;

endmodule

// ==== tb/ooo_backend_props.sv ====
`timescale 1ns/1ps

module ooo_backend_props #(
    parameter int IDX_W = 3,
    parameter int DEPTH = 8
) (
    input logic             clk,
    input logic             i_rst_n,
    input logic [1:0]       i_pick,
    input logic [IDX_W-1:0] i_idx0,
    input logic [IDX_W-1:0] i_idx1,
    input logic [1:0]       i_deq,
    input logic [1:0]       i_replay,
    input logic [DEPTH-1:0] i_ent_vld,
    input logic             i_can_enq
);

    // a lane is either dequeued or replayed
    a_deq_replay: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_deq & i_replay) == 2'b00)
        else $error("deq and replay high together in one lane");

    a_distinct_idx: assert property (@(posedge clk) disable iff (!i_rst_n)
        (&i_pick) |-> (i_idx0 != i_idx1))
        else $error("both lanes picked entry %0d", i_idx0);

    // any free slot must open the front
    a_can_enq: assert property (@(posedge clk) disable iff (!i_rst_n)
        (!(&i_ent_vld)) |-> i_can_enq)
        else $error("free entry present but can_enq low");

endmodule

bind issue_queue ooo_backend_props #(
    .IDX_W(IDX_W),
    .DEPTH(DEPTH)
) u_props (
    .clk(clk),
    .i_rst_n(i_rst_n),
    .i_pick(iq.can_issue),
    .i_idx0(iq.idx[0]),
    .i_idx1(iq.idx[1]),
    .i_deq(iq.deq),
    .i_replay(iq.replay),
    .i_ent_vld(ent_vld),
    .i_can_enq(o_can_enq)
);

// ==== tb/tb_ooo_backend.sv ====
`timescale 1ns/1ps

module tb_ooo_backend;

    localparam int N_EPOCHS   = 4;
    localparam int N_INSTR    = 24;
    localparam int CLK_PERIOD = 20;
    localparam int DEPTH      = 8;

    // epoch flavours
    localparam int MODE_CONFLICT   = 0;
    localparam int MODE_CHAIN      = 1;
    localparam int MODE_RESET_READ = 2;

    logic        clk;
    logic        i_rst_n;
    logic        i_instr_vld;
    logic [31:0] i_instr;
    logic        o_instr_rdy;
    logic [1:0]  o_wb_vld;
    logic [4:0]  o_wb_rd   [2];
    logic [31:0] o_wb_data [2];

    logic [31:0] prog    [N_INSTR];
    logic [31:0] exp_val [32];
    logic        written [32];
    string       test_name;
    int          wb_count;
    int          wb_total;
    int          value_errs;
    int          other_errs;
    int          replay_count;
    int          accepts;
    int          accepts_at_full;
    logic        seen_full;

    ooo_backend_top #(.DEPTH(DEPTH), .ISSUE_WIDTH(2)) uut (
        .clk(clk), .i_rst_n(i_rst_n), .i_instr_vld(i_instr_vld), .i_instr(i_instr),
        .o_instr_rdy(o_instr_rdy), .o_wb_vld(o_wb_vld), .o_wb_rd(o_wb_rd),
        .o_wb_data(o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // budget of 40 cycles per instruction over all epochs
    initial begin
        #(N_EPOCHS * N_INSTR * 40 * CLK_PERIOD);
        $display("timeout: writebacks stopped before every instruction completed");
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            3'd0:    return a + b;
            3'd1:    return a - b;
            3'd2:    return a & b;
            3'd3:    return a | b;
            3'd4:    return a ^ b;
            3'd5:    return a << b[4:0];
            3'd6:    return a >> b[4:0];
            default: return {31'd0, $signed(a) < $signed(b)};
        endcase
    endfunction

    task automatic build_program(input int mode);
        int          dest  [N_INSTR];
        int          avail [32];
        int          n_avail;
        int          j;
        int          tmp;
        logic        is_imm;
        logic [2:0]  op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [17:0] imm;
        logic [31:0] opb;
        for (int r = 0; r < 32; r++) begin
            exp_val[r] = (r < 8) ? 32'(r * 16 + 1) : 32'd0;
            written[r] = 1'b0;
            avail[r]   = r;
        end
        n_avail = 8;
        for (int k = 0; k < N_INSTR; k++) begin
            dest[k] = k + 8;
        end
        // shuffle destinations 8..31
        for (int k = N_INSTR - 1; k > 0; k--) begin
            j       = int'($urandom % (k + 1));
            tmp     = dest[k];
            dest[k] = dest[j];
            dest[j] = tmp;
        end
        for (int k = 0; k < N_INSTR; k++) begin
            is_imm = 1'($urandom % 2);
            op     = 3'($urandom % 8);
            rs1    = 5'(avail[$urandom % n_avail]);
            rs2    = 5'(avail[$urandom % n_avail]);
            imm    = 18'($urandom);
            if (mode == MODE_CHAIN && k > 0) begin
                rs1 = 5'(dest[k - 1]);
            end
            // two register-format ops that wake on the same writeback
            if (mode == MODE_CONFLICT && k > 0 && k < 3) begin
                is_imm = 1'b0;
                rs1    = 5'(dest[0]);
                rs2    = 5'($urandom % 8);
            end
            if (mode == MODE_RESET_READ && k < 8) begin
                is_imm = 1'b1;
                op     = 3'd0;
                rs1    = 5'(k);
                imm    = '0;
            end
            opb = is_imm ? {{14{imm[17]}}, imm} : exp_val[rs2];
            exp_val[dest[k]] = alu_model(op, exp_val[rs1], opb);
            if (is_imm) begin
                prog[k] = {1'b1, op, 5'(dest[k]), rs1, imm};
            end else begin
                prog[k] = {1'b0, op, 5'(dest[k]), rs1, rs2, 13'd0};
            end
            avail[n_avail] = dest[k];
            n_avail++;
        end
    endtask

    task automatic apply_reset();
        i_rst_n     <= 1'b0;
        i_instr_vld <= 1'b0;
        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;
    endtask

    // holds the word until the DUT takes it, returns on the accepting edge
    task automatic send_instr(input logic [31:0] word);
        i_instr_vld <= 1'b1;
        i_instr     <= word;
        @(negedge clk);
        while (!o_instr_rdy) begin
            if (!seen_full) begin
                seen_full       = 1'b1;
                accepts_at_full = accepts;
            end
            @(negedge clk);
        end
        accepts++;
        @(posedge clk);
    endtask

    task automatic check_writeback(input logic [4:0] rd, input logic [31:0] data);
        wb_count++;
        wb_total++;
        if (rd < 5'd8) begin
            other_errs++;
            $display("ERROR: %s wrote initialized register r%0d", test_name, rd);
        end else if (written[rd]) begin
            other_errs++;
            $display("ERROR: %s wrote register r%0d more than once", test_name, rd);
        end else if (data !== exp_val[rd]) begin
            value_errs++;
            $display("FAILED %s r%0d: expected %h actual %h", test_name, rd, exp_val[rd], data);
        end
        written[rd] = 1'b1;
    endtask

    task automatic watch_writebacks();
        forever begin
            @(negedge clk);
            if (i_rst_n) begin
                replay_count = replay_count + $countones(uut.iq_bus.replay);
                for (int l = 0; l < 2; l++) begin
                    if (o_wb_vld[l]) begin
                        check_writeback(o_wb_rd[l], o_wb_data[l]);
                    end
                end
            end
        end
    endtask

    task automatic run_epoch(input int mode);
        int start_replays;
        case (mode)
            MODE_CONFLICT: test_name = "port_conflict";
            MODE_CHAIN:    test_name = "queue_fill";
            default:       test_name = "reset_read";
        endcase
        apply_reset();
        build_program(mode);
        wb_count      = 0;
        accepts       = 0;
        seen_full     = 1'b0;
        start_replays = replay_count;
        for (int k = 0; k < N_INSTR; k++) begin
            send_instr(prog[k]);
        end
        i_instr_vld <= 1'b0;
        while (wb_count < N_INSTR) begin
            @(posedge clk);
        end
        // room for any stray writeback to show up
        repeat (10) @(posedge clk);
        if (wb_count != N_INSTR) begin
            other_errs++;
            $display("FAILED %s writebacks: expected %0d actual %0d", test_name, N_INSTR,
                     wb_count);
        end
        if (mode == MODE_CONFLICT && replay_count == start_replays) begin
            other_errs++;
            $display("ERROR: %s saw no replay on the read port conflict", test_name);
        end
        if (mode == MODE_CHAIN && !seen_full) begin
            other_errs++;
            $display("ERROR: %s never saw o_instr_rdy drop", test_name);
        end else if (mode == MODE_CHAIN && accepts_at_full < DEPTH) begin
            value_errs++;
            $display("FAILED %s accepts before full: expected %0d actual %0d", test_name,
                     DEPTH, accepts_at_full);
        end
    endtask

    initial begin
        void'($urandom(13604));
        i_rst_n      = 1'b0;
        i_instr_vld  = 1'b0;
        i_instr      = '0;
        wb_count     = 0;
        wb_total     = 0;
        value_errs   = 0;
        other_errs   = 0;
        replay_count = 0;
        test_name    = "init";
        fork
            watch_writebacks();
        join_none
        for (int e = 0; e < N_EPOCHS; e++) begin
            run_epoch(e % 3);
        end
        $display("summary: %0d writebacks, %0d replays, %0d value errors, %0d other errors",
                 wb_total, replay_count, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
logic/ooo_pkg.sv
logic/instr_decode.sv
logic/issue_queue.sv
logic/operand_read.sv
logic/phys_regfile.sv
logic/alu_execute.sv
logic/writeback_result.sv
logic/ooo_backend_top.sv
tb/ooo_backend_props.sv
tb/tb_ooo_backend.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ooo_backend \
    -f all.f \
    -o sim_ooo_backend

status=0
out=$(./obj_dir/sim_ooo_backend 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
    echo "run.sh: run passed"
else
    echo "run.sh: run failed"
    exit 1
fi
